/* spi_cmd_pkg.sv */
package spi_cmd_pkg;

   // command opcodes, one byte each
   localparam logic [7:0] op_nop     = 8'h00;
   localparam logic [7:0] op_init    = 8'h01;
   localparam logic [7:0] op_wr_inv  = 8'h02;
   localparam logic [7:0] op_rd_inv  = 8'h03;
   localparam logic [7:0] op_wr_leds = 8'h04;
   localparam logic [7:0] op_rd_leds = 8'h05;
   localparam logic [7:0] op_wr_vec  = 8'h06;
   localparam logic [7:0] op_rd_vec  = 8'h07;

   // vector of 24-bit values
   localparam int vec_len = 4;
   localparam int vec_idx_w = 2;

   // word FIFO geometry
   localparam int fifo_depth = 8;
   localparam int fifo_ptr_w = 3;

   // one SPI frame carries one word
   localparam int word_bits = 32;
   localparam int bit_cnt_w = 6;

   // command engine states
   localparam logic [1:0] st_idle    = 2'd0;
   localparam logic [1:0] st_collect = 2'd1;
   localparam logic [1:0] st_send    = 2'd2;

   // opcode byte on top, argument below
   typedef struct packed {
      logic [7:0]  opcode;
      logic [23:0] arg;
   } cmd_view_t;

   // vector data word, top byte ignored
   typedef struct packed {
      logic [7:0]  pad;
      logic [23:0] value;
   } data_view_t;

   typedef union packed {
      cmd_view_t  cmd;
      data_view_t data;
   } spi_word_t;

   // into a FIFO
   typedef struct packed {
      logic      push;
      spi_word_t data;
   } fifo_wr_t;

   // out of a FIFO, valid while not empty
   typedef struct packed {
      logic      valid;
      spi_word_t data;
   } fifo_rd_t;

endpackage

/* spi_word_slave.sv */
`timescale 1ns/1ps

module spi_word_slave import spi_cmd_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     sck,
   input  logic     ss_n,
   input  logic     mosi,
   output logic     miso,
   output fifo_wr_t rx_wr,
   input  logic     rx_full,
   input  fifo_rd_t tx_rd,
   output logic     tx_pop,
   output logic     overflow
);

   // two-flop synchronizers, newest sample in bit 0
   logic [1:0] sck_sync;
   logic [1:0] ss_sync;
   logic [1:0] mosi_sync;

   // edge registers
   logic sck_prev;
   logic ss_prev;

   logic sck_rise;
   logic sck_fall;
   logic ss_fall;
   logic frame_on;
   logic shift_in;
   logic word_done;

   logic [bit_cnt_w-1:0] bit_cnt;
   logic [30:0]          rx_shift;
   logic [31:0]          tx_shift;
   logic                 rx_push;
   spi_word_t            rx_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         sck_sync  <= 2'b00;
         ss_sync   <= 2'b11;
         mosi_sync <= 2'b00;
         sck_prev  <= 1'b0;
         ss_prev   <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[0], sck};
         ss_sync   <= {ss_sync[0], ss_n};
         mosi_sync <= {mosi_sync[0], mosi};
         sck_prev  <= sck_sync[1];
         ss_prev   <= ss_sync[1];
      end
   end

   assign sck_rise = sck_sync[1] & ~sck_prev;
   assign sck_fall = ~sck_sync[1] & sck_prev;
   assign ss_fall  = ~ss_sync[1] & ss_prev;
   assign frame_on = ~ss_sync[1];

   // bits past the 32nd are ignored
   assign shift_in  = frame_on & sck_rise & (bit_cnt != bit_cnt_w'(word_bits));
   assign word_done = shift_in & (bit_cnt == bit_cnt_w'(word_bits - 1));

   // frame bit counter, restarts on every chip select
   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt <= '0;
      end else if (ss_fall) begin
         bit_cnt <= '0;
      end else if (shift_in) begin
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

   // receive path
   always_ff @(posedge clk) begin
      if (shift_in) begin
         rx_shift <= {rx_shift[29:0], mosi_sync[1]};
      end
      if (word_done) begin
         rx_data <= {rx_shift, mosi_sync[1]};
      end
   end

   // push only with room in the rx FIFO, else flag the lost word
   always_ff @(posedge clk) begin
      if (rst) begin
         rx_push  <= 1'b0;
         overflow <= 1'b0;
      end else begin
         rx_push <= word_done & ~rx_full;
         if (word_done && rx_full) begin
            overflow <= 1'b1;
         end
      end
   end

   assign rx_wr = '{push: rx_push, data: rx_data};

   // transmit path
   // reply word loaded at frame start, MSB goes out first
   always_ff @(posedge clk) begin
      if (rst) begin
         tx_shift <= '0;
      end else if (ss_fall) begin
         tx_shift <= tx_rd.valid ? tx_rd.data : '0;
      end else if (frame_on && sck_fall) begin
         tx_shift <= {tx_shift[30:0], 1'b0};
      end
   end

   assign tx_pop = ss_fall & tx_rd.valid;
   assign miso   = tx_shift[31];

endmodule

/* word_fifo.sv */
`timescale 1ns/1ps

module word_fifo import spi_cmd_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  fifo_wr_t wr,
   output logic     full,
   output fifo_rd_t rd,
   input  logic     pop
);

   spi_word_t mem [fifo_depth];

   logic [fifo_ptr_w-1:0] wr_ptr;
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic [fifo_ptr_w:0]   count;
   logic                  empty;
   logic                  do_push;
   logic                  do_pop;

   assign full    = (count == (fifo_ptr_w + 1)'(fifo_depth));
   assign empty   = (count == '0);
   assign do_push = wr.push & ~full;
   assign do_pop  = pop & ~empty;

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wr.data;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign rd = '{valid: ~empty, data: mem[rd_ptr]};

endmodule

/* cmd_engine.sv */
`timescale 1ns/1ps

module cmd_engine import spi_cmd_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  fifo_rd_t    rx_rd,
   output logic        rx_pop,
   output fifo_wr_t    tx_wr,
   input  logic        tx_full,
   output logic [15:0] leds
);

   logic [1:0]           state;
   logic [vec_idx_w-1:0] idx;
   logic [15:0]          inv_reg;
   logic [23:0]          vec [vec_len];

   spi_word_t cmd_word;
   spi_word_t reply;
   logic      tx_push;
   logic      last_idx;

   assign cmd_word = rx_rd.data;
   assign last_idx = (idx == vec_idx_w'(vec_len - 1));

   // pop and reply decisions
   always_comb begin
      rx_pop  = 1'b0;
      tx_push = 1'b0;
      reply   = '0;
      case (state)
         st_idle: begin
            // a command is taken only with room for its reply
            rx_pop = rx_rd.valid & ~tx_full;
            reply.cmd.opcode = cmd_word.cmd.opcode;
            case (cmd_word.cmd.opcode)
               op_rd_inv: begin
                  reply.cmd.arg = {8'h00, inv_reg};
                  tx_push = rx_pop;
               end
               op_rd_leds: begin
                  reply.cmd.arg = {8'h00, leds};
                  tx_push = rx_pop;
               end
               default: begin
                  tx_push = 1'b0;
               end
            endcase
         end
         st_collect: begin
            rx_pop = rx_rd.valid;
         end
         st_send: begin
            // rx stays untouched until all replies are out
            tx_push = ~tx_full;
            reply.cmd.opcode = op_rd_vec;
            reply.cmd.arg = vec[idx];
         end
         default: begin
            rx_pop = 1'b0;
         end
      endcase
   end

   assign tx_wr = '{push: tx_push, data: reply};

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= st_idle;
         idx     <= '0;
         inv_reg <= '0;
         leds    <= '0;
         vec     <= '{default: '0};
      end else begin
         case (state)
            st_idle: begin
               if (rx_pop) begin
                  case (cmd_word.cmd.opcode)
                     op_init: begin
                        inv_reg <= '0;
                        leds    <= '0;
                        vec     <= '{default: '0};
                     end
                     op_wr_inv: begin
                        inv_reg <= ~cmd_word.cmd.arg[15:0];
                     end
                     op_wr_leds: begin
                        leds <= cmd_word.cmd.arg[15:0];
                     end
                     op_wr_vec: begin
                        idx   <= '0;
                        state <= st_collect;
                     end
                     op_rd_vec: begin
                        idx   <= '0;
                        state <= st_send;
                     end
                     // nop and unknown opcodes
                     default: begin
                        idx <= '0;
                     end
                  endcase
               end
            end
            st_collect: begin
               if (rx_pop) begin
                  vec[idx] <= cmd_word.data.value;
                  idx      <= idx + 1'b1;
                  if (last_idx) begin
                     state <= st_idle;
                  end
               end
            end
            st_send: begin
               if (tx_push) begin
                  idx <= idx + 1'b1;
                  if (last_idx) begin
                     state <= st_idle;
                  end
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

/* spi_cmd_top.sv */
`timescale 1ns/1ps

module spi_cmd_top import spi_cmd_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        sck,
   input  logic        ss_n,
   input  logic        mosi,
   output logic        miso,
   output logic [15:0] leds,
   output logic        overflow
);

   // slave to engine
   fifo_wr_t rx_wr;
   fifo_rd_t rx_rd;
   logic     rx_full;
   logic     rx_pop;

   // engine to slave
   fifo_wr_t tx_wr;
   fifo_rd_t tx_rd;
   logic     tx_full;
   logic     tx_pop;

   spi_word_slave slave (
      .clk      (clk),
      .rst      (rst),
      .sck      (sck),
      .ss_n     (ss_n),
      .mosi     (mosi),
      .miso     (miso),
      .rx_wr    (rx_wr),
      .rx_full  (rx_full),
      .tx_rd    (tx_rd),
      .tx_pop   (tx_pop),
      .overflow (overflow)
   );

   word_fifo rx_fifo (
      .clk  (clk),
      .rst  (rst),
      .wr   (rx_wr),
      .full (rx_full),
      .rd   (rx_rd),
      .pop  (rx_pop)
   );

   word_fifo tx_fifo (
      .clk  (clk),
      .rst  (rst),
      .wr   (tx_wr),
      .full (tx_full),
      .rd   (tx_rd),
      .pop  (tx_pop)
   );

   cmd_engine engine (
      .clk     (clk),
      .rst     (rst),
      .rx_rd   (rx_rd),
      .rx_pop  (rx_pop),
      .tx_wr   (tx_wr),
      .tx_full (tx_full),
      .leds    (leds)
   );

endmodule

/* tb_spi_cmd.sv */
`timescale 1ns/1ps

module tb_spi_cmd import spi_cmd_pkg::*; ();

   // SPI timing in clk cycles
   localparam int reset_cycles = 8;
   localparam int sck_half     = 4;
   localparam int lead_cycles  = 8;
   localparam int tail_cycles  = 4;
   localparam int gap_cycles   = 16;
   localparam int frame_cycles = 1 + lead_cycles + word_bits * 2 * sck_half
                                 + tail_cycles + gap_cycles;

   localparam int n_pair = 20;
   localparam int n_mix  = 60;

   // worst case frames, counting every mix command as a vector write
   localparam int max_frames  = 10 + 2 * (n_pair + fifo_depth) + 10 + 24
                                + (vec_len + 1) * n_mix + fifo_depth;
   localparam int cycle_limit = reset_cycles + 8 + max_frames * frame_cycles + 500;

   logic        clk = 1'b0;
   logic        rst;
   logic        sck;
   logic        ss_n;
   logic        mosi;
   logic        miso;
   logic [15:0] leds;
   logic        overflow;

   logic [31:0] rng_state = 32'h1b33_a54d;
   int          errors;
   int          checks;
   int          errors_mark;
   int          cycle_cnt;

   // reference model
   logic [15:0] model_leds;
   logic [15:0] model_inv;
   logic [23:0] model_vec [vec_len];
   logic [31:0] reply_q [$];
   int          collect_left;

   spi_cmd_top UUT (
      .clk      (clk),
      .rst      (rst),
      .sck      (sck),
      .ss_n     (ss_n),
      .mosi     (mosi),
      .miso     (miso),
      .leds     (leds),
      .overflow (overflow)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // reply words a command adds to the tx queue
   function automatic int reply_count(input logic [7:0] op);
      if (op == op_rd_inv || op == op_rd_leds) begin
         return 1;
      end else if (op == op_rd_vec) begin
         return vec_len;
      end
      return 0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      end
   endtask

   task automatic model_clear();
      model_leds = '0;
      model_inv  = '0;
      for (int k = 0; k < vec_len; k++) begin
         model_vec[k] = '0;
      end
   endtask

   // one mode 0 frame with miso captured just before each rising SCK
   task automatic spi_frame(input logic [31:0] tx, output logic [31:0] rx);
      rx = '0;
      @(negedge clk);
      ss_n = 1'b0;
      repeat (lead_cycles) @(negedge clk);
      for (int i = word_bits - 1; i >= 0; i--) begin
         mosi = tx[i];
         repeat (sck_half) @(negedge clk);
         rx[i] = miso;
         sck = 1'b1;
         repeat (sck_half) @(negedge clk);
         sck = 1'b0;
      end
      repeat (tail_cycles) @(negedge clk);
      ss_n = 1'b1;
      mosi = 1'b0;
      repeat (gap_cycles) @(negedge clk);
   endtask

   // send a word, check miso against the queue head, then update the model
   task automatic send_word(input logic [31:0] w);
      logic [31:0] expected;
      logic [31:0] got;
      logic [7:0]  op;
      expected = '0;
      if (reply_q.size() > 0) begin
         expected = reply_q.pop_front();
      end
      spi_frame(w, got);
      check_value("miso", got, expected);
      op = w[31:24];
      if (collect_left > 0) begin
         model_vec[vec_len - collect_left] = w[23:0];
         collect_left--;
      end else begin
         case (op)
            op_init:    model_clear();
            op_wr_inv:  model_inv = ~w[15:0];
            op_rd_inv:  reply_q.push_back({op_rd_inv, 8'h00, model_inv});
            op_wr_leds: model_leds = w[15:0];
            op_rd_leds: reply_q.push_back({op_rd_leds, 8'h00, model_leds});
            op_wr_vec:  collect_left = vec_len;
            op_rd_vec: begin
               for (int k = 0; k < vec_len; k++) begin
                  reply_q.push_back({op_rd_vec, model_vec[k]});
               end
            end
            default: begin
            end
         endcase
      end
      check_value("leds", {16'h0000, leds}, {16'h0000, model_leds});
   endtask

   task automatic drain_replies();
      while (reply_q.size() > 0) begin
         send_word({op_nop, 24'h000000});
      end
   endtask

   task automatic write_vector();
      send_word({op_wr_vec, 24'h000000});
      for (int k = 0; k < vec_len; k++) begin
         send_word(next_rand());
      end
   endtask

   task automatic read_all();
      send_word({op_rd_inv, 24'h000000});
      send_word({op_rd_leds, 24'h000000});
      send_word({op_rd_vec, 24'h000000});
      drain_replies();
   endtask

   task automatic report_test(input string name);
      $display("test %-14s %0d errors", name, errors - errors_mark);
      errors_mark = errors;
   endtask

   task automatic random_pairs(input logic [7:0] wr_op, input logic [7:0] rd_op);
      logic [31:0] r;
      for (int i = 0; i < n_pair; i++) begin
         r = next_rand();
         if (r[0]) begin
            send_word({wr_op, r[31:8]});
         end else begin
            send_word({rd_op, r[31:8]});
         end
      end
      drain_replies();
   endtask

   task automatic random_command();
      logic [31:0] r;
      logic [31:0] arg;
      logic [7:0]  op;
      r   = next_rand();
      arg = next_rand();
      if (r[3:0] == 4'hf) begin
         // opcodes above op_rd_vec
         op = {1'b0, r[14:8]} + 8'h08;
      end else begin
         op = {5'b00000, r[2:0]};
      end
      // keep the tx FIFO from stalling the engine
      if (reply_count(op) + reply_q.size() > fifo_depth) begin
         op = op_nop;
      end
      if (op == op_wr_vec) begin
         write_vector();
      end else begin
         send_word({op, arg[23:0]});
      end
   endtask

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: no result after %0d clk cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      sck          = 1'b0;
      ss_n         = 1'b1;
      mosi         = 1'b0;
      errors       = 0;
      checks       = 0;
      errors_mark  = 0;
      collect_left = 0;
      model_clear();
      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;
      repeat (4) @(negedge clk);

      check_value("leds", {16'h0000, leds}, 32'h0);
      read_all();
      report_test("reset values");

      random_pairs(op_wr_leds, op_rd_leds);
      report_test("leds");

      random_pairs(op_wr_inv, op_rd_inv);
      report_test("inverted");

      write_vector();
      send_word({op_rd_vec, 24'h000000});
      drain_replies();
      report_test("vector");

      send_word({op_wr_leds, 24'(next_rand())});
      send_word({op_wr_inv, 24'(next_rand())});
      write_vector();
      send_word({op_init, 24'h000000});
      read_all();
      send_word({op_nop, 24'h000000});
      send_word({op_nop, 24'h000000});
      report_test("init");

      for (int i = 0; i < n_mix; i++) begin
         random_command();
      end
      drain_replies();
      check_value("overflow", {31'h0, overflow}, 32'h0);
      report_test("random mix");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* spi_cmd.f */
spi_cmd_pkg.sv
spi_word_slave.sv
word_fifo.sv
cmd_engine.sv
spi_cmd_top.sv
tb_spi_cmd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SPI command slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_spi_cmd \
   -f spi_cmd.f -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "PASS: all tests" "$log_file"; then
   exit 0
else
   exit 1
fi
